//--- list.f
+incdir+source
source/core_pkg.sv
source/fetch_unit.sv
source/decode_stage.sv
source/register_file.sv
source/execute_stage.sv
source/io_store_unit.sv
source/core_top.sv
sim/core_tb.sv

//--- run.sh
#!/bin/sh
# Build the core testbench with Verilator, run it and look for the pass line in the log
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert -Wno-fatal --top-module core_tb -f list.f -o core_sim \
	&& ./obj_dir/core_sim | tee sim.log \
	&& grep -qx "TEST PASS" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

//--- sim/core_tb.sv
// Testbench of the pipeline core
// Clock, reset, instruction memory slave and I/O slave on Wishbone classic
// ISA reference model, value check task, directed tests, cycle timeout
`timescale 1ns/1ps
`default_nettype none
`include "core_config.svh"

module core_tb;

	import core_pkg::*;

	localparam int PROG_WORDS = 64;
	localparam int TIMEOUT_CYCLES = 3000;   // Five tests of a few hundred cycles at most

	logic    clk;
	logic    reset = 1'b1;
	wb_req_t ibus_req;
	wb_rsp_t ibus_rsp = '0;
	wb_req_t iobus_req;
	wb_rsp_t iobus_rsp = '0;
	logic    halt;

	logic [31:0] program_mem [PROG_WORDS];
	int          prog_len;
	logic [31:0] exp_adr [$];             // Model stores in program order
	logic [31:0] exp_dat [$];
	logic [31:0] log_adr [$];             // Writes seen on the I/O bus
	logic [31:0] log_dat [$];
	logic [31:0] rand_state = 32'd34;     // Immediates
	logic [31:0] wait_state = 32'd34;     // Fetch wait states
	bit          fetch_random;            // Zero-wait fetch when clear
	int          io_wait;                 // I/O ack delay of the running test
	logic        ibus_armed;
	int          ibus_left;
	logic        iobus_armed;
	int          iobus_left;
	int          cycle_count = 0;
	int          error_count = 0;
	int          pass_count = 0;
	int          fail_count = 0;

	core_top DUT (.clk(clk), .reset(reset), .ibus_req(ibus_req), .ibus_rsp(ibus_rsp),
		.iobus_req(iobus_req), .iobus_rsp(iobus_rsp), .halt(halt));

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;   // 100 ns period
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic logic [31:0] encode(input int op, input int rd, input int rs1,
		input int rs2, input int imm);
		return {op[3:0], rd[3:0], rs1[3:0], rs2[3:0], imm[15:0]};
	endfunction

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected)
		begin
			$display("ERROR at %0t: %s is %h, expected %h", $time, what, actual, expected);
			error_count++;
		end
	endtask

	task automatic draw_imm(output logic [15:0] imm);
		rand_state = lcg_next(rand_state);
		imm = rand_state[30:15];   // Upper bits, better spread
	endtask

	// Unused words decode as HALT, low bits carry the word address
	task automatic clear_program();
		for (int i = 0; i < PROG_WORDS; i++)
			program_mem[i] = {`OP_HALT, i[27:0]};
		prog_len = 0;
	endtask

	task automatic emit(input logic [31:0] word);
		program_mem[prog_len] = word;
		prog_len++;
	endtask

	// Sequential ISA model, stops at the first HALT
	task automatic compute_model();
		logic [31:0] regs [`REG_COUNT];
		logic [31:0] instr;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		int          pc;
		bit          done;
		exp_adr.delete();
		exp_dat.delete();
		for (int i = 0; i < `REG_COUNT; i++)
			regs[i] = '0;
		pc = 0;
		done = 1'b0;
		while (!done && pc < PROG_WORDS)
		begin
			instr = program_mem[pc];
			a = regs[instr[23:20]];
			b = regs[instr[19:16]];
			imm = {{16{instr[15]}}, instr[15:0]};
			pc++;
			case (instr[31:28])
				`OP_ADD:  regs[instr[27:24]] = a + b;
				`OP_SUB:  regs[instr[27:24]] = a - b;
				`OP_AND:  regs[instr[27:24]] = a & b;
				`OP_OR:   regs[instr[27:24]] = a | b;
				`OP_XOR:  regs[instr[27:24]] = a ^ b;
				`OP_ADDI: regs[instr[27:24]] = a + imm;
				`OP_STORE:
				begin
					exp_adr.push_back(a + imm);
					exp_dat.push_back(b);
				end
				`OP_HALT: done = 1'b1;
				default:  ;   // No-op
			endcase
			regs[0] = '0;   // r0 reads zero
		end
	endtask

	task automatic apply_reset();
		@(posedge clk);
		reset <= 1'b1;
		@(negedge clk);
		check_value(32'(ibus_req.cyc), 32'd0, "instruction bus cyc in reset");
		check_value(32'(iobus_req.cyc), 32'd0, "I/O bus cyc in reset");
		check_value(32'(halt), 32'd0, "halt in reset");
		repeat (3) @(posedge clk);   // Three cycles in reset
		reset <= 1'b0;
	endtask

	task automatic compare_stores();
		check_value(32'(log_adr.size()), 32'(exp_adr.size()), "number of I/O writes");
		for (int i = 0; i < exp_adr.size() && i < log_adr.size(); i++)
		begin
			check_value(log_adr[i], exp_adr[i], $sformatf("address of write %0d", i));
			check_value(log_dat[i], exp_dat[i], $sformatf("data of write %0d", i));
		end
	endtask

	// Reset, run to halt, drain the I/O bus, compare and report
	task automatic run_program(input string name, input bit random_fetch, input int io_delay);
		int errors_before;
		errors_before = error_count;
		fetch_random = random_fetch;
		io_wait = io_delay;
		compute_model();
		apply_reset();
		@(negedge clk);
		while (!ibus_req.stb)
			@(negedge clk);
		check_value(ibus_req.adr, 32'h0000_0000, "first fetch address");
		while (!halt)
			@(negedge clk);
		while (iobus_req.cyc)   // Last store may still be on the bus
		begin
			check_value(32'(ibus_req.cyc), 32'd0, "instruction bus cyc after halt");
			@(negedge clk);
		end
		repeat (4)
		begin
			check_value(32'(ibus_req.cyc), 32'd0, "instruction bus cyc after halt");
			@(negedge clk);
		end
		check_value(32'(halt), 32'd1, "halt held");
		compare_stores();
		if (error_count == errors_before)
			pass_count++;
		else
			fail_count++;
		$display("Test %s finished with %0d errors", name, error_count - errors_before);
	endtask

	task automatic test_reset_state();
		clear_program();
		emit(encode(`OP_STORE, 0, 0, 0, 'h10));
		emit(encode(`OP_HALT, 0, 0, 0, 0));
		run_program("reset state", 1'b1, 0);
	endtask

	task automatic test_alu_ops();
		logic [15:0] imm [4];
		for (int i = 0; i < 4; i++)
			draw_imm(imm[i]);
		clear_program();
		emit(encode(`OP_ADDI, 1, 0, 0, imm[0]));
		emit(encode(`OP_ADDI, 2, 0, 0, imm[1]));
		emit(encode(`OP_ADDI, 3, 1, 0, imm[2]));
		emit(encode(`OP_ADD, 4, 1, 2, 0));
		emit(encode(`OP_SUB, 5, 1, 2, 0));
		emit(encode(`OP_AND, 6, 2, 3, 0));
		emit(encode(`OP_OR, 7, 3, 1, 0));
		emit(encode(`OP_XOR, 8, 1, 2, 0));
		emit(encode(`OP_ADDI, 0, 1, 0, imm[3]));   // Write to r0 is dropped
		emit(encode(9, 1, 2, 3, 'h1234));          // Unused opcode, no-op
		for (int r = 0; r <= 8; r++)
			emit(encode(`OP_STORE, 0, 0, r, 'h100 + 4 * r));
		emit(encode(`OP_HALT, 0, 0, 0, 0));
		run_program("ALU operations", 1'b1, 0);
	endtask

	task automatic test_bypass_chain();
		logic [15:0] imm;
		draw_imm(imm);
		clear_program();
		emit(encode(`OP_ADDI, 1, 0, 0, imm));
		emit(encode(`OP_ADD, 2, 1, 1, 0));
		emit(encode(`OP_SUB, 3, 2, 1, 0));
		emit(encode(`OP_XOR, 4, 3, 2, 0));
		emit(encode(`OP_OR, 5, 4, 1, 0));
		emit(encode(`OP_AND, 6, 5, 4, 0));
		emit(encode(`OP_ADDI, 7, 6, 0, -3));
		emit(encode(`OP_ADD, 7, 7, 7, 0));       // Reads its own last result
		emit(encode(`OP_ADDI, 9, 0, 0, 'h300));
		emit(encode(`OP_STORE, 0, 9, 7, 8));     // Base just written
		for (int r = 2; r <= 6; r++)
			emit(encode(`OP_STORE, 0, 0, r, 'h200 + 4 * r));
		emit(encode(`OP_HALT, 0, 0, 0, 0));
		run_program("dependent chain", 1'b0, 0);
	endtask

	task automatic test_backpressure();
		logic [15:0] imm;
		clear_program();
		for (int r = 1; r <= 6; r++)
		begin
			draw_imm(imm);
			emit(encode(`OP_ADDI, r, 0, 0, imm));
		end
		for (int r = 1; r <= 6; r++)
			emit(encode(`OP_STORE, 0, 0, r, 'h400 + 4 * r));   // Back to back
		emit(encode(`OP_ADD, 7, 1, 2, 0));   // Follows a stalled store
		emit(encode(`OP_STORE, 0, 0, 7, 'h440));
		emit(encode(`OP_HALT, 0, 0, 0, 0));
		run_program("I/O back-pressure", 1'b0, 3);
	endtask

	task automatic test_halt_stops();
		clear_program();
		emit(encode(`OP_ADDI, 1, 0, 0, 'h55));
		emit(encode(`OP_STORE, 0, 0, 1, 'h500));
		emit(encode(`OP_STORE, 0, 0, 1, 'h504));
		emit(encode(`OP_HALT, 0, 0, 0, 0));
		emit(encode(`OP_STORE, 0, 0, 1, 'h508));   // Never reached
		emit(encode(`OP_STORE, 0, 0, 1, 'h50C));
		run_program("halt", 1'b1, 2);
	endtask

	// Instruction memory slave, 0 to 3 random wait cycles
	always @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			ibus_rsp <= '0;
			ibus_armed <= 1'b0;
			ibus_left <= 0;
		end
		else
		begin
			ibus_rsp.ack <= 1'b0;   // Single-cycle ack
			if (ibus_req.stb && !ibus_rsp.ack)
			begin
				if (!ibus_armed)
				begin
					ibus_armed <= 1'b1;
					wait_state <= lcg_next(wait_state);
					ibus_left <= fetch_random ? int'(wait_state[17:16]) : 0;
				end
				else if (ibus_left == 0)
				begin
					check_value(32'(ibus_req.we), 32'd0, "instruction bus write enable");
					ibus_rsp.ack <= 1'b1;
					ibus_rsp.dat <= program_mem[ibus_req.adr[7:2]];
					ibus_armed <= 1'b0;
				end
				else
					ibus_left <= ibus_left - 1;
			end
		end
	end

	// I/O slave, fixed delay per test, logs each completed write
	always @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			iobus_rsp <= '0;
			iobus_armed <= 1'b0;
			iobus_left <= 0;
			log_adr.delete();
			log_dat.delete();
		end
		else
		begin
			iobus_rsp.ack <= 1'b0;
			if (iobus_req.stb && !iobus_rsp.ack)
			begin
				if (!iobus_armed)
				begin
					iobus_armed <= 1'b1;
					iobus_left <= io_wait;
				end
				else if (iobus_left == 0)
				begin
					check_value(32'(iobus_req.we), 32'd1, "I/O write enable");
					log_adr.push_back(iobus_req.adr);
					log_dat.push_back(iobus_req.dat);
					iobus_rsp.ack <= 1'b1;
					iobus_armed <= 1'b0;
				end
				else
					iobus_left <= iobus_left - 1;
			end
		end
	end

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TEST FAIL");
			$finish;
		end
	end

	initial
	begin
		test_reset_state();
		test_alu_ops();
		test_bypass_chain();
		test_backpressure();
		test_halt_stops();
		$display("Tests passed: %0d, failed: %0d, errors: %0d", pass_count, fail_count,
			error_count);
		if (fail_count == 0 && error_count == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- source/core_top.sv
// Pipeline core top level
// Fetch, decode, register file, execute and I/O store unit
// Instruction bus and I/O bus, both Wishbone classic
`timescale 1ns/1ps
`default_nettype none
`include "core_config.svh"

module core_top
(
	input  logic              clk,
	input  logic              reset,
	output core_pkg::wb_req_t ibus_req,
	input  core_pkg::wb_rsp_t ibus_rsp,
	output core_pkg::wb_req_t iobus_req,
	input  core_pkg::wb_rsp_t iobus_rsp,
	output logic              halt
);

	import core_pkg::*;

	fetched_t                  fetched;
	decoded_t                  decoded;
	reg_write_t                reg_write;
	io_store_t                 io_store;
	logic                      stall;       // Store back-pressure
	logic                      io_busy;
	logic [`REG_SEL_WIDTH-1:0] read_sel1;
	logic [`REG_SEL_WIDTH-1:0] read_sel2;
	logic [`DATA_WIDTH-1:0]    read_value1;
	logic [`DATA_WIDTH-1:0]    read_value2;

	fetch_unit fetch_unit (.clk(clk), .reset(reset), .stall(stall), .ibus_rsp(ibus_rsp),
		.ibus_req(ibus_req), .fetched(fetched));

	decode_stage decode_stage (.clk(clk), .reset(reset), .stall(stall), .fetched(fetched),
		.read_sel1(read_sel1), .read_sel2(read_sel2), .decoded(decoded));

	register_file register_file (.clk(clk), .reset(reset), .read_sel1(read_sel1),
		.read_sel2(read_sel2), .reg_write(reg_write), .read_value1(read_value1),
		.read_value2(read_value2));

	execute_stage execute_stage (.clk(clk), .reset(reset), .decoded(decoded),
		.read_value1(read_value1), .read_value2(read_value2), .io_busy(io_busy),
		.stall(stall), .reg_write(reg_write), .io_store(io_store), .halt(halt));

	io_store_unit io_store_unit (.clk(clk), .reset(reset), .io_store(io_store),
		.iobus_rsp(iobus_rsp), .io_busy(io_busy), .iobus_req(iobus_req));

endmodule

`default_nettype wire

//--- source/io_store_unit.sv
// I/O store unit
// Latches one store request and runs a Wishbone classic write until ack
`timescale 1ns/1ps
`default_nettype none
`include "core_config.svh"

module io_store_unit
(
	input  logic                clk,
	input  logic                reset,
	input  core_pkg::io_store_t io_store,
	input  core_pkg::wb_rsp_t   iobus_rsp,
	output logic                io_busy,
	output core_pkg::wb_req_t   iobus_req
);

	logic                   active;   // Write cycle open on the bus
	logic                   accept;
	logic [`DATA_WIDTH-1:0] adr_r;
	logic [`DATA_WIDTH-1:0] dat_r;

	assign accept = io_store.valid && !active;
	assign io_busy = active;   // Busy from the edge after accept until ack

	assign iobus_req.cyc = active;
	assign iobus_req.stb = active;
	assign iobus_req.we = active;   // Writes only
	assign iobus_req.adr = adr_r;
	assign iobus_req.dat = dat_r;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			active <= 1'b0;
		else if (accept)
			active <= 1'b1;   // cyc and stb one cycle after accept
		else if (iobus_rsp.ack)
			active <= 1'b0;   // Idle at least one cycle
	end

	// Store payload
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			adr_r <= io_store.adr;
			dat_r <= io_store.dat;
		end
	end

	a_stb_in_cyc: assert property (@(posedge clk) disable iff (reset)
		iobus_req.stb |-> iobus_req.cyc);

endmodule

`default_nettype wire

//--- source/execute_stage.sv
// Execute stage
// Operand bypass from the execute and writeback registers, ALU
// Store issue to the I/O unit with stall on back-pressure, sticky halt
`timescale 1ns/1ps
`default_nettype none
`include "core_config.svh"

module execute_stage
(
	input  logic                   clk,
	input  logic                   reset,
	input  core_pkg::decoded_t     decoded,
	input  logic [`DATA_WIDTH-1:0] read_value1,
	input  logic [`DATA_WIDTH-1:0] read_value2,
	input  logic                   io_busy,
	output logic                   stall,
	output core_pkg::reg_write_t   reg_write,
	output core_pkg::io_store_t    io_store,
	output logic                   halt
);

	import core_pkg::*;

	typedef struct packed {
		logic       halt;
		reg_write_t wr;
	} stage_reg_t;

	stage_reg_t             ex_r;       // Execute register
	stage_reg_t             wb_r;       // Writeback register
	stage_reg_t             ex_next;
	logic                   halt_seen;
	logic                   is_store;
	logic [`DATA_WIDTH-1:0] op1;
	logic [`DATA_WIDTH-1:0] op2;

	// Newest result wins, r0 never forwarded
	function automatic logic [`DATA_WIDTH-1:0] forward(input logic [`REG_SEL_WIDTH-1:0] sel,
		input logic [`DATA_WIDTH-1:0] rf_value, input reg_write_t ex_wr, input reg_write_t wb_wr);
		if (sel != '0 && ex_wr.en && ex_wr.sel == sel)
			return ex_wr.value;
		if (sel != '0 && wb_wr.en && wb_wr.sel == sel)
			return wb_wr.value;
		return rf_value;
	endfunction

	assign op1 = forward(decoded.rs1, read_value1, ex_r.wr, wb_r.wr);
	assign op2 = forward(decoded.rs2, read_value2, ex_r.wr, wb_r.wr);

	always_comb
	begin
		ex_next.halt = decoded.valid && decoded.opcode == `OP_HALT;
		ex_next.wr.en = decoded.valid && decoded.writes_reg;
		ex_next.wr.sel = decoded.rd;
		case (decoded.opcode)
			`OP_ADD:  ex_next.wr.value = op1 + op2;
			`OP_SUB:  ex_next.wr.value = op1 - op2;
			`OP_AND:  ex_next.wr.value = op1 & op2;
			`OP_OR:   ex_next.wr.value = op1 | op2;
			`OP_XOR:  ex_next.wr.value = op1 ^ op2;
			`OP_ADDI: ex_next.wr.value = op1 + decoded.imm;
			default:  ex_next.wr.value = '0;
		endcase
	end

	assign is_store = decoded.valid && decoded.opcode == `OP_STORE;
	assign stall = is_store && io_busy;             // Store waits in decode register
	assign io_store.valid = is_store && !io_busy;   // Handed over in this cycle
	assign io_store.adr = op1 + decoded.imm;
	assign io_store.dat = op2;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			ex_r <= '0;
			wb_r <= '0;
			halt_seen <= 1'b0;
		end
		else
		begin
			if (stall)
				wb_r <= '0;   // Bubble while execute holds
			else
			begin
				ex_r <= ex_next;
				wb_r <= ex_r;
			end
			if (wb_r.halt)
				halt_seen <= 1'b1;   // Stays until reset
		end
	end

	assign reg_write = wb_r.wr;   // Written at the next edge
	assign halt = wb_r.halt || halt_seen;

	// Issued store occupies the I/O unit from the next cycle
	a_store_handoff: assert property (@(posedge clk) disable iff (reset)
		io_store.valid |=> io_busy);

endmodule

`default_nettype wire

//--- source/register_file.sv
// Scalar register file
// Sixteen 32-bit registers, two combinational read ports, one write port
// Register 0 is never written and reads zero
`timescale 1ns/1ps
`default_nettype none
`include "core_config.svh"

module register_file
(
	input  logic                      clk,
	input  logic                      reset,
	input  logic [`REG_SEL_WIDTH-1:0] read_sel1,
	input  logic [`REG_SEL_WIDTH-1:0] read_sel2,
	input  core_pkg::reg_write_t      reg_write,
	output logic [`DATA_WIDTH-1:0]    read_value1,
	output logic [`DATA_WIDTH-1:0]    read_value2
);

	logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < `REG_COUNT; i++)
				regs[i] <= '0;
		end
		else if (reg_write.en && reg_write.sel != '0)
			regs[reg_write.sel] <= reg_write.value;   // r0 write dropped
	end

	assign read_value1 = regs[read_sel1];
	assign read_value2 = regs[read_sel2];

	a_r0_zero: assert property (@(posedge clk) disable iff (reset)
		reg_write.en && reg_write.sel == '0 |=> regs[0] == '0);

endmodule

`default_nettype wire

//--- source/decode_stage.sv
// Decode stage
// Instruction field split and immediate sign extension
// Decode pipeline register with hold on stall, register file read selects
`timescale 1ns/1ps
`default_nettype none
`include "core_config.svh"

module decode_stage
(
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      stall,
	input  core_pkg::fetched_t        fetched,
	output logic [`REG_SEL_WIDTH-1:0] read_sel1,
	output logic [`REG_SEL_WIDTH-1:0] read_sel2,
	output core_pkg::decoded_t        decoded
);

	import core_pkg::*;

	decoded_t decode_next;

	always_comb
	begin
		decode_next.valid = fetched.valid;
		decode_next.opcode = fetched.instr[31:28];
		decode_next.rd = fetched.instr[27:24];
		decode_next.rs1 = fetched.instr[23:20];
		decode_next.rs2 = fetched.instr[19:16];   // Store data for STORE
		decode_next.imm = {{(`DATA_WIDTH - `IMM_WIDTH){fetched.instr[`IMM_WIDTH-1]}},
			fetched.instr[`IMM_WIDTH-1:0]};
		case (decode_next.opcode)
			`OP_ADD, `OP_SUB, `OP_AND, `OP_OR, `OP_XOR, `OP_ADDI:
				decode_next.writes_reg = 1'b1;
			default:
				decode_next.writes_reg = 1'b0;   // STORE, HALT, no-ops
		endcase
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			decoded <= '0;
		else if (!stall)
			decoded <= decode_next;   // Held while the store waits
	end

	// Register file is read while the instruction sits in this register
	assign read_sel1 = decoded.rs1;
	assign read_sel2 = decoded.rs2;

endmodule

`default_nettype wire

//--- source/fetch_unit.sv
// Instruction fetch unit
// Program counter and Wishbone classic read master, one read at a time
// One-word hold buffer toward decode, stops after a HALT word
`timescale 1ns/1ps
`default_nettype none
`include "core_config.svh"

module fetch_unit
(
	input  logic               clk,
	input  logic               reset,
	input  logic               stall,
	input  core_pkg::wb_rsp_t  ibus_rsp,
	output core_pkg::wb_req_t  ibus_req,
	output core_pkg::fetched_t fetched
);

	logic                   busy;        // Read cycle open on the bus
	logic                   halted;      // HALT word seen
	logic [`DATA_WIDTH-1:0] pc;          // Address of the open or next read
	logic                   buf_valid;
	logic [`DATA_WIDTH-1:0] buf_pc;
	logic [`DATA_WIDTH-1:0] buf_instr;
	logic                   read_done;
	logic                   start_read;

	assign read_done = busy && ibus_rsp.ack;          // Ack only counts inside a cycle
	assign start_read = !busy && !halted && !stall;  // Gap of one cycle after each ack

	assign ibus_req.cyc = busy;
	assign ibus_req.stb = busy;
	assign ibus_req.we = 1'b0;   // Reads only
	assign ibus_req.adr = pc;
	assign ibus_req.dat = '0;

	assign fetched.valid = buf_valid;
	assign fetched.pc = buf_pc;
	assign fetched.instr = buf_instr;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			halted <= 1'b0;
			pc <= `RESET_PC;
			buf_valid <= 1'b0;
		end
		else
		begin
			if (start_read)
				busy <= 1'b1;
			else if (read_done)
				busy <= 1'b0;   // Drop cyc and stb on the ack edge
			if (read_done)
				pc <= pc + 'd4;
			if (read_done && ibus_rsp.dat[31:28] == `OP_HALT)
				halted <= 1'b1;   // No further reads
			if (read_done)
				buf_valid <= 1'b1;
			else if (!stall)
				buf_valid <= 1'b0;   // Decode took the word
		end
	end

	// Hold buffer payload
	always_ff @(posedge clk)
	begin
		if (read_done)
		begin
			buf_pc <= pc;
			buf_instr <= ibus_rsp.dat;
		end
	end

	a_adr_aligned: assert property (@(posedge clk) disable iff (reset)
		ibus_req.stb |-> ibus_req.adr[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- source/core_pkg.sv
// Shared types of the pipeline core
// Wishbone classic request and response
// Fetched and decoded instruction, register write, I/O store request
`default_nettype none
`include "core_config.svh"

package core_pkg;

	typedef struct packed {
		logic                   cyc;
		logic                   stb;
		logic                   we;
		logic [`DATA_WIDTH-1:0] adr;
		logic [`DATA_WIDTH-1:0] dat;  // Write data
	} wb_req_t;

	typedef struct packed {
		logic                   ack;
		logic [`DATA_WIDTH-1:0] dat;  // Read data
	} wb_rsp_t;

	typedef struct packed {
		logic                   valid;
		logic [`DATA_WIDTH-1:0] pc;
		logic [`DATA_WIDTH-1:0] instr;
	} fetched_t;

	typedef struct packed {
		logic                     valid;
		logic [3:0]               opcode;
		logic [`REG_SEL_WIDTH-1:0] rd;
		logic [`REG_SEL_WIDTH-1:0] rs1;
		logic [`REG_SEL_WIDTH-1:0] rs2;
		logic [`DATA_WIDTH-1:0]   imm;         // Already sign-extended
		logic                     writes_reg;  // ALU op with a result
	} decoded_t;

	typedef struct packed {
		logic                     en;
		logic [`REG_SEL_WIDTH-1:0] sel;
		logic [`DATA_WIDTH-1:0]   value;
	} reg_write_t;

	typedef struct packed {
		logic                   valid;
		logic [`DATA_WIDTH-1:0] adr;
		logic [`DATA_WIDTH-1:0] dat;
	} io_store_t;

endpackage

`default_nettype wire

//--- source/core_config.svh
// Core configuration macros
// Data, immediate and register select widths
// Register count and reset program counter
// Opcode encodings of the four-bit opcode field
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

`define DATA_WIDTH    32            // Data and address width
`define REG_COUNT     16            // Scalar registers
`define REG_SEL_WIDTH 4             // Register number width
`define IMM_WIDTH     16            // Immediate field width
`define RESET_PC      32'h0000_0000 // First fetch address

`define OP_ADD   4'd0
`define OP_SUB   4'd1
`define OP_AND   4'd2
`define OP_OR    4'd3
`define OP_XOR   4'd4
`define OP_ADDI  4'd5  // rs1 plus sign-extended immediate
`define OP_STORE 4'd6  // I/O write of rs2
`define OP_HALT  4'd15

`endif
